//--- Makefile
TOP = execCore_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f execCore.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f execCore.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

//--- dv/execCore_asserts.sv
`timescale 1ns/1ps
`include "execCore_cfg.svh"

module execCore_asserts (
    input logic        Clk,
    input logic        rstN,
    input logic        wbValid,
    input logic [4:0]  wbReg,
    input logic [31:0] wbData
);

    // A pulse always names a real, nonzero register
    property pulseHasDest;
        @(posedge Clk) disable iff (!rstN)
            wbValid |-> (wbReg != 5'd0) && (int'(wbReg) < `REG_COUNT);
    endproperty

    property resetClearsValid;
        @(posedge Clk) !rstN |=> !wbValid;
    endproperty

    property dataKnown;
        @(posedge Clk) disable iff (!rstN)
            wbValid |-> !$isunknown(wbData);
    endproperty

    assert property (pulseHasDest) else $error("wbValid high with register 0 as target");
    assert property (resetClearsValid) else $error("wbValid high right after reset");
    assert property (dataKnown) else $error("wbData unknown while wbValid is high");

endmodule

bind execCore execCore_asserts u_execCore_asserts (
    .Clk(Clk), .rstN(rstN), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
);

//--- dv/execCore_stimulus.txt
// Columns: instruction word, expected wbValid, expected wbReg, expected wbData (hex)
// wbReg and wbData are not compared on lines where wbValid is 0
00A00821 1 01 00000000  // ADDU r1, r5, r0 after reset
3C031234 1 03 12340000  // LUI r3, 0x1234
34635678 1 03 12345678  // ORI r3, r3, 0x5678
2404FFFF 1 04 FFFFFFFF  // ADDIU r4, r0, -1
20050080 1 05 00000080  // ADDI r5, r0, 0x80
30868001 1 06 00008001  // ANDI r6, r4, 0x8001
3867FFFF 1 07 1234A987  // XORI r7, r3, 0xffff
2888FFFE 1 08 00000000  // SLTI r8, r4, -2
2CA9FFFF 1 09 00000001  // SLTIU r9, r5, -1
288A0000 1 0A 00000001  // SLTI r10, r4, 0
00655821 1 0B 123456F8  // ADDU r11, r3, r5
00A36023 1 0C EDCBAA08  // SUBU r12, r5, r3
00676824 1 0D 12340000  // AND r13, r3, r7
00A67025 1 0E 00008081  // OR r14, r5, r6
00677826 1 0F 0000FFFF  // XOR r15, r3, r7
0085802A 1 10 00000001  // SLT r16, r4, r5
00058900 1 11 00000800  // SLL r17, r5, 4
00039202 1 12 00123456  // SRL r18, r3, 8
00239A02 1 13 78123456  // ROTR r19, r3, 8
24150004 1 15 00000004  // ADDIU r21, r0, 4
02A3A006 1 14 01234567  // SRLV r20, r3, r21
02A3B046 1 16 81234567  // ROTRV r22, r3, r21
7C07BC20 1 17 FFFFFF87  // SEB r23, r7
7C07C620 1 18 FFFFA987  // SEH r24, r7
AC030010 0 00 00000000  // SW r3, 0x10(r0)
8C190010 1 19 12345678  // LW r25, 0x10(r0)
A0070011 0 00 00000000  // SB r7, 0x11(r0)
A4070012 0 00 00000000  // SH r7, 0x12(r0)
8C1A0010 1 1A A9878778  // LW r26, 0x10(r0)
801B0011 1 1B FFFFFF87  // LB r27, 0x11(r0)
801C0010 1 1C 00000078  // LB r28, 0x10(r0)
841D0012 1 1D FFFFA987  // LH r29, 0x12(r0)
8CBFFF90 1 1F A9878778  // LW r31, -0x70(r5)
00000000 0 00 00000000  // NOP word
10220004 0 00 00000000  // BEQ r1, r2, 4
04810008 0 00 00000000  // BGEZ r4, 8
08000100 0 00 00000000  // J 0x100
0C000040 0 00 00000000  // JAL 0x40
70654002 0 00 00000000  // MUL r8, r3, r5
74040010 0 00 00000000  // LA
24600005 0 00 00000000  // ADDIU r0, r3, 5
00650021 0 00 00000000  // ADDU r0, r3, r5
00080821 1 01 00000000  // ADDU r1, r0, r8 shows r8 kept

//--- dv/execCore_tb.sv
`timescale 1ns/1ps

module execCore_tb;
    import isaPkg::*;

    localparam int MaxTests    = 64;
    localparam int ClkPeriod   = 100;
    localparam int ResetCycles = 16;

    logic        Clk;
    logic        rstN;
    logic        instrValid;
    instrWord_u  instr;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    logic [31:0] stim [0:4*MaxTests-1];  // Word, valid, reg, data per test
    int          numTests;
    bit          loaded;
    int          checks;
    int          errors;
    integer      seed;

    execCore u_execCore (
        .Clk(Clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    always #(ClkPeriod/2) Clk = ~Clk;

    // --------------------------------------------------
    task automatic loadStimulus();
        for (int i = 0; i < 4*MaxTests; i++) begin
            stim[i] = ~i;  // Never 0 or 1 in the valid column
        end
        $readmemh("dv/execCore_stimulus.txt", stim);
        numTests = 0;
        while (numTests < MaxTests && stim[4*numTests+1] <= 32'd1) begin
            numTests++;
        end
    endtask

    // Register and data only matter on a pulse
    task automatic checkOutputs(input string name, input logic expValid,
                                input logic [4:0] expReg, input logic [31:0] expData);
        checks++;
        assert (wbValid === expValid) else begin
            $display("[FAIL] %s wbValid expected %0b actual %0b", name, expValid, wbValid);
            errors++;
        end
        if (expValid) begin
            assert (wbReg === expReg) else begin
                $display("[FAIL] %s wbReg expected %0d actual %0d", name, expReg, wbReg);
                errors++;
            end
            assert (wbData === expData) else begin
                $display("[FAIL] %s wbData expected %08h actual %08h", name, expData, wbData);
                errors++;
            end
        end
    endtask

    // --------------------------------------------------
    initial begin
        int    gap;
        string name;
        Clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        checks     = 0;
        errors     = 0;
        seed       = 32'ha8ff486e;
        loadStimulus();
        loaded = 1'b1;
        if (numTests == 0) begin
            $display("No test lines found in the stimulus file");
            errors++;
        end

        repeat (ResetCycles) @(posedge Clk);
        rstN <= 1'b1;
        @(negedge Clk);
        checks++;
        assert (wbValid === 1'b0 && wbReg === 5'd0 && wbData === 32'd0) else begin
            $display("[FAIL] reset state expected 0/0/00000000 actual %0b/%0d/%08h",
                     wbValid, wbReg, wbData);
            errors++;
        end

        if (numTests > 0) begin
            @(posedge Clk);
            instr      <= stim[0];
            instrValid <= 1'b1;
        end
        for (int i = 0; i < numTests; i++) begin
            gap = $random(seed) & 3;  // Idle cycles after this one
            @(posedge Clk);           // DUT takes instruction i
            if (gap == 0 && i + 1 < numTests) begin
                instr      <= stim[4*(i+1)];
                instrValid <= 1'b1;
            end else begin
                instr      <= $random(seed);  // Junk word while idle
                instrValid <= 1'b0;
            end
            @(negedge Clk);
            name = $sformatf("test %0d (%08h)", i, stim[4*i]);
            checkOutputs(name, stim[4*i+1][0], stim[4*i+2][4:0], stim[4*i+3]);
            // Strobe low, so the junk word gives no pulse
            for (int k = 0; k < gap; k++) begin
                @(posedge Clk);
                if (k == gap - 1 && i + 1 < numTests) begin
                    instr      <= stim[4*(i+1)];
                    instrValid <= 1'b1;
                end
                @(negedge Clk);
                name = $sformatf("idle %0d after test %0d", k, i);
                checkOutputs(name, 1'b0, 5'd0, 32'd0);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Worst case is four cycles per test plus reset
    initial begin
        int limit;
        wait (loaded);
        limit = numTests * 5 + 40;
        repeat (limit) @(posedge Clk);
        $display("Timeout: run did not complete within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- execCore.f
+incdir+logic
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/controlDecoder.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/dataMemory.sv
logic/writebackStage.sv
logic/execCore.sv
dv/execCore_asserts.sv
dv/execCore_tb.sv

//--- logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  isaPkg::instrWord_u instr,
    input  logic [31:0]        rsData,
    input  logic [31:0]        rtData,
    input  logic               aluBMux,
    input  ctrlPkg::aluOp_e    aluOp,
    output logic [31:0]        aluResult
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [31:0] immExt;
    logic [31:0] operandB;
    logic [4:0]  shiftAmt;
    logic        isVarShift;

    function automatic logic [31:0] rotateRight(
        input logic [31:0] value,
        input logic [4:0]  amount
    );
        logic [63:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[31:0];
    endfunction

    always_comb begin
        if (aluOp == aluAndi || aluOp == aluOri || aluOp == aluXori) begin
            immExt = {16'b0, instr.iType.imm16};  // Logical immediates zero-extend
        end else begin
            immExt = {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
        end
    end

    assign operandB   = aluBMux ? immExt : rtData;
    assign isVarShift = (aluOp == aluSrlv) || (aluOp == aluRotrv);
    assign shiftAmt   = isVarShift ? rsData[4:0] : instr.rType.shamt;

    // --------------------------------------------------
    // Operation select
    always_comb begin
        case (aluOp)
            aluRType: begin
                case (instr.rType.funct)
                    functAddu: aluResult = rsData + operandB;
                    functSubu: aluResult = rsData - operandB;
                    functAnd:  aluResult = rsData & operandB;
                    functOr:   aluResult = rsData | operandB;
                    functXor:  aluResult = rsData ^ operandB;
                    functSlt:  aluResult = {31'b0, $signed(rsData) < $signed(operandB)};
                    functSll:  aluResult = operandB << shiftAmt;
                    default:   aluResult = '0;
                endcase
            end
            aluAddi, aluAddiu: aluResult = rsData + operandB;
            aluLui:            aluResult = {instr.iType.imm16, 16'b0};
            aluAndi:           aluResult = rsData & operandB;
            aluOri:            aluResult = rsData | operandB;
            aluXori:           aluResult = rsData ^ operandB;
            aluSlti:           aluResult = {31'b0, $signed(rsData) < $signed(operandB)};
            aluSltiu:          aluResult = {31'b0, rsData < operandB};  // Sign-extended imm
            aluSrl, aluSrlv:   aluResult = rtData >> shiftAmt;
            aluRotr, aluRotrv: aluResult = rotateRight(rtData, shiftAmt);
            aluSeb:            aluResult = {{24{rtData[7]}}, rtData[7:0]};
            aluSeh:            aluResult = {{16{rtData[15]}}, rtData[15:0]};
            default:           aluResult = '0;  // Branches jumps and unexecuted ops
        endcase
    end

endmodule

//--- logic/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
    input  isaPkg::instrWord_u instr,
    output logic               aluBMux,
    output logic               memRead,
    output logic               memWrite,
    output logic               regWrite,
    output ctrlPkg::aluOp_e    aluOp,
    output ctrlPkg::regDst_e   regDst,
    output ctrlPkg::byteSig_e  byteSig,
    output ctrlPkg::memToReg_e memToReg
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       bit21;  // ROTR when set
    logic       bit16;  // BGEZ when set
    logic       bit6;   // ROTRV when set

    assign opcode = instr.rType.opcode;
    assign funct  = instr.rType.funct;
    assign bit21  = instr.rType.rs[0];
    assign bit16  = instr.iType.rt[0];
    assign bit6   = instr.rType.shamt[0];

    always_comb begin
        aluBMux  = 1'b0;  // Safe defaults give a NOP
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        aluOp    = aluRType;
        regDst   = rtDst;
        byteSig  = bsWord;
        memToReg = srcAlu;

        if (instr != '0) begin
            case (opcode)
                opZero: begin
                    if (funct == functJr) begin
                        aluOp = aluJump;
                    end else begin
                        regWrite = 1'b1;
                        regDst   = rdDst;
                        if (funct == functSrl) begin
                            if (bit21) aluOp = aluRotr;
                            else       aluOp = aluSrl;
                        end else if (funct == functSrlv) begin
                            if (bit6) aluOp = aluRotrv;
                            else      aluOp = aluSrlv;
                        end
                    end
                end
                opSebSeh: begin
                    regDst = rdDst;
                    if (instr.rType.shamt == saSeb) begin
                        aluOp    = aluSeb;
                        regWrite = 1'b1;
                    end else if (instr.rType.shamt == saSeh) begin
                        aluOp    = aluSeh;
                        regWrite = 1'b1;
                    end
                end
                opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                    aluBMux  = 1'b1;
                    regWrite = 1'b1;
                    case (opcode)
                        opAddi:  aluOp = aluAddi;  // No overflow trap here
                        opAddiu: aluOp = aluAddiu;
                        opSlti:  aluOp = aluSlti;
                        opSltiu: aluOp = aluSltiu;
                        opAndi:  aluOp = aluAndi;
                        opOri:   aluOp = aluOri;
                        opXori:  aluOp = aluXori;
                        default: aluOp = aluLui;
                    endcase
                end
                opLb, opLh, opLw: begin
                    aluBMux  = 1'b1;
                    aluOp    = aluAddi;  // Base plus offset
                    memRead  = 1'b1;
                    regWrite = 1'b1;
                    memToReg = srcLoad;
                    if (opcode == opLb)      byteSig = bsByte;
                    else if (opcode == opLh) byteSig = bsHalf;
                end
                opSb, opSh, opSw: begin
                    aluBMux  = 1'b1;
                    aluOp    = aluAddi;
                    memWrite = 1'b1;
                    if (opcode == opSb)      byteSig = bsByte;
                    else if (opcode == opSh) byteSig = bsHalf;
                end
                opBgezBltz: begin
                    if (bit16) aluOp = aluBgez;
                    else       aluOp = aluBltz;
                end
                opBeq:  aluOp = aluBeq;
                opBne:  aluOp = aluBne;
                opBlez: aluOp = aluBlez;
                opBgtz: aluOp = aluBgtz;
                opJ:    aluOp = aluJump;
                opJal: begin
                    aluOp  = aluJump;  // Link write not carried out
                    regDst = linkDst;
                end
                // Decoded but not executed
                opMadd: begin
                    aluOp  = aluMul;
                    regDst = rdDst;
                end
                opExi:   aluOp = aluExi;
                opLa:    aluOp = aluLa;
                default: aluOp = aluRType;
            endcase
        end
    end

endmodule

//--- logic/ctrlPkg.sv
package ctrlPkg;

    // --------------------------------------------------
    // ALU operation codes
    typedef enum logic [5:0] {
        aluRType = 6'd0,   // ALU decodes funct
        aluAddiu = 6'd1,
        aluAddi  = 6'd2,   // Also the load/store address add
        aluMul   = 6'd3,
        aluLui   = 6'd4,
        aluBltz  = 6'd5,
        aluBeq   = 6'd6,
        aluBne   = 6'd7,
        aluBgtz  = 6'd8,
        aluBlez  = 6'd9,
        aluBgez  = 6'd10,
        aluJump  = 6'd11,  // J JR JAL
        aluAndi  = 6'd12,
        aluOri   = 6'd13,
        aluXori  = 6'd14,
        aluSeb   = 6'd15,
        aluSlti  = 6'd16,
        aluSltiu = 6'd17,
        aluSrl   = 6'd18,
        aluRotr  = 6'd19,
        aluSrlv  = 6'd20,
        aluSeh   = 6'd21,
        aluRotrv = 6'd22,
        aluExi   = 6'd23,
        aluLa    = 6'd24
    } aluOp_e;

    typedef enum logic [1:0] {
        rtDst   = 2'b00,
        rdDst   = 2'b01,
        linkDst = 2'b10   // Register 31
    } regDst_e;

    typedef enum logic [1:0] {
        bsWord = 2'b00,
        bsHalf = 2'b01,
        bsByte = 2'b10
    } byteSig_e;

    typedef enum logic [1:0] {
        srcAlu  = 2'b00,
        srcLoad = 2'b01
    } memToReg_e;

endpackage

//--- logic/dataMemory.sv
`timescale 1ns/1ps
`include "execCore_cfg.svh"

module dataMemory (
    input  logic              Clk,
    input  logic              memWrite,
    input  logic              memRead,
    input  ctrlPkg::byteSig_e byteSig,
    input  logic [31:0]       addr,
    input  logic [31:0]       storeData,
    output logic [31:0]       loadData
);
    import ctrlPkg::*;

    localparam int Depth = 2 ** `DMEM_ADDR_BITS;

    logic [31:0]                mem [Depth];
    logic [`DMEM_ADDR_BITS-1:0] wordIdx;
    logic [31:0]                wordData;
    logic [3:0]                 laneEn;
    logic [31:0]                laneData;
    logic [7:0]                 loadByte;
    logic [15:0]                loadHalf;

    assign wordIdx  = addr[`DMEM_ADDR_BITS+1:2];  // Upper address bits wrap
    assign wordData = mem[wordIdx];
    assign loadByte = wordData[8*addr[1:0] +: 8];
    assign loadHalf = wordData[16*addr[1] +: 16];  // Bit 0 ignored

    // --------------------------------------------------
    // Store lanes
    always_comb begin
        case (byteSig)
            bsByte: begin
                laneEn   = 4'b0001 << addr[1:0];
                laneData = {4{storeData[7:0]}};
            end
            bsHalf: begin
                laneEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{storeData[15:0]}};
            end
            default: begin
                laneEn   = 4'b1111;
                laneData = storeData;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (memWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (laneEn[lane]) begin
                    mem[wordIdx][8*lane +: 8] <= laneData[8*lane +: 8];
                end
            end
        end
    end

    always_comb begin
        loadData = '0;
        if (memRead) begin
            case (byteSig)
                bsByte:  loadData = {{24{loadByte[7]}}, loadByte};
                bsHalf:  loadData = {{16{loadHalf[15]}}, loadHalf};
                default: loadData = wordData;
            endcase
        end
    end

endmodule

//--- logic/execCore.sv
`timescale 1ns/1ps

module execCore (
    input  logic               Clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  isaPkg::instrWord_u instr,
    output logic               wbValid,
    output logic [4:0]         wbReg,
    output logic [31:0]        wbData
);
    import ctrlPkg::*;

    // Decoder outputs
    logic        aluBMux;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    aluOp_e      aluOp;
    regDst_e     regDst;
    byteSig_e    byteSig;
    memToReg_e   memToReg;

    // Datapath
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;

    controlDecoder u_controlDecoder (
        .instr(instr),
        .aluBMux(aluBMux), .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
        .aluOp(aluOp), .regDst(regDst), .byteSig(byteSig), .memToReg(memToReg)
    );

    registerFile u_registerFile (
        .Clk(Clk), .rstN(rstN),
        .rsAddr(instr.rType.rs), .rtAddr(instr.rType.rt),
        .rsData(rsData), .rtData(rtData),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    aluUnit u_aluUnit (
        .instr(instr), .rsData(rsData), .rtData(rtData),
        .aluBMux(aluBMux), .aluOp(aluOp), .aluResult(aluResult)
    );

    // Memory acts only on accepted instructions
    dataMemory u_dataMemory (
        .Clk(Clk),
        .memWrite(memWrite & instrValid),
        .memRead(memRead & instrValid),
        .byteSig(byteSig), .addr(aluResult), .storeData(rtData),
        .loadData(loadData)
    );

    writebackStage u_writebackStage (
        .Clk(Clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
        .aluResult(aluResult), .loadData(loadData),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

endmodule

//--- logic/execCore_cfg.svh
`ifndef EXECCORE_CFG_SVH
`define EXECCORE_CFG_SVH

// Data memory holds 2**DMEM_ADDR_BITS words
`define DMEM_ADDR_BITS 8
`define REG_COUNT 32

`endif

//--- logic/isaPkg.sv
package isaPkg;

    // --------------------------------------------------
    // Primary opcodes
    localparam logic [5:0] opZero     = 6'b000000;  // R-type with funct
    localparam logic [5:0] opBgezBltz = 6'b000001;  // Split by bit 16
    localparam logic [5:0] opJ        = 6'b000010;
    localparam logic [5:0] opJal      = 6'b000011;
    localparam logic [5:0] opBeq      = 6'b000100;
    localparam logic [5:0] opBne      = 6'b000101;
    localparam logic [5:0] opBlez     = 6'b000110;
    localparam logic [5:0] opBgtz     = 6'b000111;
    localparam logic [5:0] opAddi     = 6'b001000;
    localparam logic [5:0] opAddiu    = 6'b001001;
    localparam logic [5:0] opSlti     = 6'b001010;
    localparam logic [5:0] opSltiu    = 6'b001011;
    localparam logic [5:0] opAndi     = 6'b001100;
    localparam logic [5:0] opOri      = 6'b001101;
    localparam logic [5:0] opXori     = 6'b001110;
    localparam logic [5:0] opLui      = 6'b001111;
    localparam logic [5:0] opExi      = 6'b011001;  // EH IH DH EB IB
    localparam logic [5:0] opMadd     = 6'b011100;  // MADD MSUB MUL
    localparam logic [5:0] opLa       = 6'b011101;
    localparam logic [5:0] opSebSeh   = 6'b011111;  // Split by sa field
    localparam logic [5:0] opLb       = 6'b100000;
    localparam logic [5:0] opLh       = 6'b100001;
    localparam logic [5:0] opLw       = 6'b100011;
    localparam logic [5:0] opSb       = 6'b101000;
    localparam logic [5:0] opSh       = 6'b101001;
    localparam logic [5:0] opSw       = 6'b101011;

    // --------------------------------------------------
    // R-type funct codes
    localparam logic [5:0] functSll  = 6'b000000;
    localparam logic [5:0] functSrl  = 6'b000010;  // Also ROTR with bit 21
    localparam logic [5:0] functSrlv = 6'b000110;  // Also ROTRV with bit 6
    localparam logic [5:0] functJr   = 6'b001000;
    localparam logic [5:0] functAddu = 6'b100001;
    localparam logic [5:0] functSubu = 6'b100011;
    localparam logic [5:0] functAnd  = 6'b100100;
    localparam logic [5:0] functOr   = 6'b100101;
    localparam logic [5:0] functXor  = 6'b100110;
    localparam logic [5:0] functSlt  = 6'b101010;

    localparam logic [4:0] saSeb = 5'b10000;  // Sub-decode in the shamt slot
    localparam logic [4:0] saSeh = 5'b11000;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields_s;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeFields_s;

    // One instruction word seen as either format
    typedef union packed {
        rTypeFields_s rType;
        iTypeFields_s iType;
    } instrWord_u;

endpackage

//--- logic/registerFile.sv
`timescale 1ns/1ps
`include "execCore_cfg.svh"

module registerFile (
    input  logic        Clk,
    input  logic        rstN,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    logic [31:0] regs [`REG_COUNT];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads see a write right after its edge
    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

//--- logic/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
    input  logic               Clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  isaPkg::instrWord_u instr,
    input  logic               regWrite,
    input  ctrlPkg::regDst_e   regDst,
    input  ctrlPkg::memToReg_e memToReg,
    input  logic [31:0]        aluResult,
    input  logic [31:0]        loadData,
    output logic               wrEn,
    output logic [4:0]         wrAddr,
    output logic [31:0]        wrData,
    output logic               wbValid,
    output logic [4:0]         wbReg,
    output logic [31:0]        wbData
);
    import ctrlPkg::*;

    always_comb begin
        case (regDst)
            rdDst:   wrAddr = instr.rType.rd;
            linkDst: wrAddr = 5'd31;
            default: wrAddr = instr.iType.rt;
        endcase
    end

    assign wrData = (memToReg == srcLoad) ? loadData : aluResult;
    assign wrEn   = instrValid && regWrite && (wrAddr != 5'd0);  // Writes to r0 dropped

    // Port holds the last result between pulses
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            wbReg   <= '0;
            wbData  <= '0;
        end else begin
            wbValid <= wrEn;
            if (wrEn) begin
                wbReg  <= wrAddr;
                wbData <= wrData;
            end
        end
    end

endmodule
